// ==== Makefile ====
# Verilator build for the fixed-point multiply unit

VERILATOR ?= verilator
TOP       ?= vfx_mul_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
logic/vfx_types_pkg.sv
logic/vcsr_pkg.sv
logic/vmul_prod_if.sv
logic/vfx_csr.sv
logic/vmul_simd.sv
logic/vsmul.sv
logic/vfx_mul_unit.sv
dv/vfx_mul_unit_tb.sv

// ==== dv/vfx_mul_unit_tb.sv ====
// Fixed-point multiply unit testbench
`timescale 1ns/1ps
`default_nettype none

module vfx_mul_unit_tb
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
();

    localparam int N_RAND     = 24;
    localparam int CLK_PERIOD = 100;

    typedef struct {
        sew_t   sew;
        vxrm_t  vxrm;
        bus64_t vs1;
        bus64_t vs2;
        bus64_t vd;
        logic   sat;
    } row_t;

    typedef struct {
        bus64_t vd;
        logic   sat;
        int     cyc;
    } exp_t;

    logic      clk_i;
    logic      rst_i;
    logic      csr_we_i;
    csr_addr_t csr_addr_i;
    csr_data_t csr_wdata_i;
    csr_data_t csr_rdata_o;
    logic      valid_i;
    bus64_t    vs1_i;
    bus64_t    vs2_i;
    logic      valid_o;
    bus64_t    vd_o;
    logic      sat_o;

    row_t        rows[$];
    exp_t        exp_q[$];
    // configuration the DUT holds after the last driven write
    sew_t        m_sew;
    vxrm_t       m_vxrm;
    logic [31:0] lfsr_q;
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;

    vfx_mul_unit #(.ELEN(ELEN_C)) uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .valid_i     (valid_i),
        .vs1_i       (vs1_i),
        .vs2_i       (vs2_i),
        .valid_o     (valid_o),
        .vd_o        (vd_o),
        .sat_o       (sat_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // --------------------------------------------------
    // stimulus table and reference model
    // --------------------------------------------------
    task automatic add_row(sew_t s, vxrm_t m, bus64_t a, bus64_t b, bus64_t vd, logic sat);
        row_t r;
        r = '{s, m, a, b, vd, sat};
        rows.push_back(r);
    endtask

    // halfway products with kept lsb even and odd and a negative lane where it fits
    task automatic load_table();
        add_row(SEW_8,  RNU_V, 64'h00F80C08, 64'h00081008, 64'h0201, 1'b0);
        add_row(SEW_8,  RNE_V, 64'h00F80C08, 64'h00081008, 64'h0200, 1'b0);
        add_row(SEW_8,  RDN_V, 64'h00F80C08, 64'h00081008, 64'h00FF0100, 1'b0);
        add_row(SEW_8,  ROD_V, 64'h00F80C08, 64'h00081008, 64'h00FF0101, 1'b0);
        add_row(SEW_8,  RNU_V, 64'h4080, 64'h4080, 64'h207F, 1'b1);
        add_row(SEW_16, RNU_V, 64'hFF80_00C0_0080, 64'h0080_0100_0080, 64'h2_0001, 1'b0);
        add_row(SEW_16, RNE_V, 64'hFF80_00C0_0080, 64'h0080_0100_0080, 64'h2_0000, 1'b0);
        add_row(SEW_16, RDN_V, 64'hFF80_00C0_0080, 64'h0080_0100_0080, 64'hFFFF_0001_0000, 1'b0);
        add_row(SEW_16, ROD_V, 64'hFF80_00C0_0080, 64'h0080_0100_0080, 64'hFFFF_0001_0001, 1'b0);
        add_row(SEW_16, RNU_V, 64'h4000_8000, 64'h4000_8000, 64'h2000_7FFF, 1'b1);
        add_row(SEW_32, RNU_V, 64'hC000_0000_8000, 64'h1_0000_0000_8000, 64'h2_0000_0001, 1'b0);
        add_row(SEW_32, RNE_V, 64'hC000_0000_8000, 64'h1_0000_0000_8000, 64'h2_0000_0000, 1'b0);
        add_row(SEW_32, RDN_V, 64'hC000_0000_8000, 64'h1_0000_0000_8000, 64'h1_0000_0000, 1'b0);
        add_row(SEW_32, ROD_V, 64'hC000_0000_8000, 64'h1_0000_0000_8000, 64'h1_0000_0001, 1'b0);
        add_row(SEW_32, RNU_V, 64'h4000_0000_8000_0000, 64'h4000_0000_8000_0000,
                64'h2000_0000_7FFF_FFFF, 1'b1);
        add_row(SEW_64, RNU_V, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
                64'h7FFF_FFFF_FFFF_FFFF, 1'b1);
        add_row(SEW_64, RNU_V, 64'h8000_0000, 64'h8000_0000, 64'h1, 1'b0);
        add_row(SEW_64, RNE_V, 64'h8000_0000, 64'h8000_0000, 64'h0, 1'b0);
        add_row(SEW_64, RDN_V, 64'hC000_0000, 64'h1_0000_0000, 64'h1, 1'b0);
        add_row(SEW_64, ROD_V, 64'h8000_0000, 64'h8000_0000, 64'h1, 1'b0);
    endtask

    // returns {sat, vd} from exact products at 128 bits
    function automatic logic [64:0] model_result(sew_t sew, vxrm_t mode, bus64_t a, bus64_t b);
        int                  w;
        logic [127:0]        mask;
        logic signed [127:0] ea;
        logic signed [127:0] eb;
        logic signed [127:0] p;
        logic signed [127:0] r;
        logic signed [127:0] maxv;
        logic                g;
        logic                st;
        logic                l;
        logic                inc;
        logic                sat;
        bus64_t              vd;
        w    = 8 << int'(sew);
        mask = (128'd1 << w) - 128'd1;
        maxv = (128'sd1 <<< (w - 1)) - 128'sd1;
        sat  = 1'b0;
        vd   = '0;
        for (int k = 0; k < 64 / w; k++) begin
            ea = (128'(a) >> (k * w)) & mask;
            eb = (128'(b) >> (k * w)) & mask;
            if (ea[w-1]) begin
                ea = ea | ~mask;
            end
            if (eb[w-1]) begin
                eb = eb | ~mask;
            end
            p  = ea * eb;
            g  = p[w-2];
            st = |(p & ((128'd1 << (w - 2)) - 128'd1));
            l  = p[w-1];
            case (mode)
                RNU_V:   inc = g;
                RNE_V:   inc = g & (st | l);
                ROD_V:   inc = ~l & (g | st);
                default: inc = 1'b0;
            endcase
            r = p >>> (w - 1);
            r = r + 128'(inc);
            if (r > maxv) begin
                r   = maxv;
                sat = 1'b1;
            end
            vd = vd | (64'(r & mask) << (k * w));
        end
        return {sat, vd};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic bus64_t draw_bits(int n);
        bus64_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[62:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // --------------------------------------------------
    // driving and checking
    // --------------------------------------------------
    task automatic expect_val(string what, bus64_t got, bus64_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive(logic v, bus64_t a, bus64_t b, logic we, csr_addr_t addr,
                         csr_data_t data);
        @(posedge clk_i);
        #5;
        valid_i     = v;
        vs1_i       = a;
        vs2_i       = b;
        csr_we_i    = we;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        // the write lands on the next edge after this cycle's operation is captured
        if (we && addr == CSR_VSEW) begin
            m_sew = sew_t'(data[1:0]);
        end
        if (we && addr == CSR_VXRM) begin
            m_vxrm = vxrm_t'(data[1:0]);
        end
    endtask

    task automatic issue(bus64_t a, bus64_t b, bus64_t vd, logic sat, logic we,
                         csr_addr_t addr, csr_data_t data);
        exp_t e;
        drive(1'b1, a, b, we, addr, data);
        e.vd  = vd;
        e.sat = sat;
        e.cyc = cyc;
        exp_q.push_back(e);
    endtask

    task automatic read_csr(csr_addr_t addr, csr_data_t exp, string what);
        drive(1'b0, '0, '0, 1'b0, addr, '0);
        #40;
        expect_val(what, 64'(csr_rdata_o), 64'(exp));
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            drive(1'b0, '0, '0, 1'b0, CSR_VXSAT, '0);
        end
    endtask

    task automatic report_test(string name, int mark);
        $display("test %s: %s", name, (errors == mark) ? "ok" : "failed");
    endtask

    // each result is matched against the oldest outstanding operation
    always @(negedge clk_i) begin : monitor
        exp_t e;
        if (!rst_i && valid_o) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("valid_o went high at %0d ns with no operation outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                expect_val("vd_o", vd_o, e.vd);
                expect_val("sat_o", 64'(sat_o), 64'(e.sat));
                expect_val("latency in cycles", 64'(cyc - e.cyc), 64'd2);
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = ((rows.size() + N_RAND + 8) * 4 + 5) * CLK_PERIOD;
        #(limit);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int          mark;
        logic [64:0] res;
        bus64_t      a;
        bus64_t      b;
        logic [1:0]  cfg;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        csr_we_i    = 1'b0;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        valid_i     = 1'b0;
        vs1_i       = '0;
        vs2_i       = '0;
        lfsr_q      = 32'd72653;
        m_sew       = SEW_8;
        m_vxrm      = RNU_V;
        load_table();
        repeat (5) @(posedge clk_i);
        #5;
        rst_i = 1'b0;

        mark = errors;
        expect_val("valid_o after reset", 64'(valid_o), 64'd0);
        expect_val("sat_o after reset", 64'(sat_o), 64'd0);
        expect_val("vd_o after reset", vd_o, 64'd0);
        read_csr(CSR_VXRM, 8'd0, "vxrm after reset");
        read_csr(CSR_VSEW, 8'd0, "sew after reset");
        read_csr(CSR_VXSAT, 8'd0, "vxsat after reset");
        report_test("reset state", mark);

        mark = errors;
        foreach (rows[i]) begin
            drive(1'b0, '0, '0, 1'b1, CSR_VSEW, 8'(rows[i].sew));
            drive(1'b0, '0, '0, 1'b1, CSR_VXRM, 8'(rows[i].vxrm));
            issue(rows[i].vs1, rows[i].vs2, rows[i].vd, rows[i].sat, 1'b0, CSR_VXSAT, '0);
        end
        wait_drain();
        report_test("rounding and saturation table", mark);

        // the table ends with non-saturating rows after the last saturating one
        mark = errors;
        read_csr(CSR_VXSAT, 8'd1, "vxsat after saturation");
        drive(1'b0, '0, '0, 1'b1, CSR_VXSAT, 8'd0);
        read_csr(CSR_VXSAT, 8'd0, "vxsat after clear");
        report_test("sticky vxsat", mark);

        // one configuration write per issue alternating between SEW and vxrm
        mark = errors;
        for (int i = 0; i < N_RAND; i++) begin
            a   = draw_bits(64);
            b   = draw_bits(64);
            cfg = 2'(draw_bits(2));
            res = model_result(m_sew, m_vxrm, a, b);
            issue(a, b, res[63:0], res[64], 1'b1, (i % 2 == 0) ? CSR_VSEW : CSR_VXRM, 8'(cfg));
        end
        wait_drain();
        report_test("back-to-back random", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/vcsr_pkg.sv ====
// Fixed-point control registers
`default_nettype none

package vcsr_pkg;

    // vxrm rounding modes
    typedef enum logic [1:0] {
        RNU_V = 2'd0,
        RNE_V = 2'd1,
        RDN_V = 2'd2,
        ROD_V = 2'd3
    } vxrm_t;

    // --------------------------------------------------
    // register port
    // --------------------------------------------------
    typedef logic [1:0] csr_addr_t;
    typedef logic [7:0] csr_data_t;

    localparam csr_addr_t CSR_VXSAT = 2'd0;
    localparam csr_addr_t CSR_VXRM  = 2'd1;
    localparam csr_addr_t CSR_VSEW  = 2'd2;

endpackage

`default_nettype wire

// ==== logic/vfx_csr.sv ====
// Fixed-point control registers
`timescale 1ns/1ps
`default_nettype none

module vfx_csr
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  csr_data_t csr_wdata_i,
    output csr_data_t csr_rdata_o,
    input  logic      sat_set_i,
    output sew_t      sew_o,
    output vxrm_t     vxrm_o
);

    vxrm_t vxrm_q;
    sew_t  sew_q;
    logic  vxsat_q;

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vxrm_q  <= RNU_V;
            sew_q   <= SEW_8;
            vxsat_q <= 1'b0;
        end else begin
            if (csr_we_i && csr_addr_i == CSR_VXRM) begin
                vxrm_q <= vxrm_t'(csr_wdata_i[1:0]);
            end
            if (csr_we_i && csr_addr_i == CSR_VSEW) begin
                sew_q <= sew_t'(csr_wdata_i[1:0]);
            end
            // a saturating result beats a write in the same cycle
            if (sat_set_i) begin
                vxsat_q <= 1'b1;
            end else if (csr_we_i && csr_addr_i == CSR_VXSAT) begin
                vxsat_q <= csr_wdata_i[0];
            end
        end
    end

    // read data, zero-extended
    always_comb begin
        case (csr_addr_i)
            CSR_VXSAT: csr_rdata_o = csr_data_t'(vxsat_q);
            CSR_VXRM:  csr_rdata_o = csr_data_t'(vxrm_q);
            CSR_VSEW:  csr_rdata_o = csr_data_t'(sew_q);
            default:   csr_rdata_o = '0;
        endcase
    end

    assign sew_o  = sew_q;
    assign vxrm_o = vxrm_q;

endmodule

`default_nettype wire

// ==== logic/vfx_mul_unit.sv ====
// Fixed-point vector multiply unit
`timescale 1ns/1ps
`default_nettype none

module vfx_mul_unit
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
#(
    parameter int ELEN = ELEN_C
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  csr_data_t csr_wdata_i,
    output csr_data_t csr_rdata_o,
    input  logic      valid_i,
    input  bus64_t    vs1_i,
    input  bus64_t    vs2_i,
    output logic      valid_o,
    output bus64_t    vd_o,
    output logic      sat_o
);

    sew_t  cur_sew;
    vxrm_t cur_vxrm;

    vmul_prod_if prod_if ();

    // control registers, vxsat fed back from the result stage
    vfx_csr u_csr (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .sat_set_i   (sat_o),
        .sew_o       (cur_sew),
        .vxrm_o      (cur_vxrm)
    );

    vmul_simd #(.ELEN(ELEN)) u_mul (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .vs1_i   (vs1_i),
        .vs2_i   (vs2_i),
        .sew_i   (cur_sew),
        .vxrm_i  (cur_vxrm),
        .prod    (prod_if.mul_mp)
    );

    vsmul #(.ELEN(ELEN)) u_rnd (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .prod      (prod_if.rnd_mp),
        .valid_o   (valid_o),
        .data_vd_o (vd_o),
        .sat_ovf_o (sat_o)
    );

endmodule

`default_nettype wire

// ==== logic/vfx_types_pkg.sv ====
// Fixed-point lane types
`default_nettype none

package vfx_types_pkg;

    // --------------------------------------------------
    // lane geometry
    // --------------------------------------------------
    // width of one vector lane in bits
    localparam int ELEN_C = 64;

    // element width, encoded as in vtype.vsew
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // --------------------------------------------------
    // data words
    // --------------------------------------------------
    // operand or result word
    typedef logic [ELEN_C-1:0] bus64_t;
    // double-width product word
    typedef logic [2*ELEN_C-1:0] bus128_t;

endpackage

`default_nettype wire

// ==== logic/vmul_prod_if.sv ====
// Product stage boundary
`timescale 1ns/1ps
`default_nettype none

interface vmul_prod_if
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
();

    logic    valid;
    bus128_t prod;
    // configuration captured with the operands
    sew_t    sew;
    vxrm_t   vxrm;

    modport mul_mp (output valid, output prod, output sew, output vxrm);

    modport rnd_mp (input valid, input prod, input sew, input vxrm);

endinterface

`default_nettype wire

// ==== logic/vmul_simd.sv ====
// SIMD signed multiplier
`timescale 1ns/1ps
`default_nettype none

module vmul_simd
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
#(
    parameter int ELEN = ELEN_C
) (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   valid_i,
    input  bus64_t vs1_i,
    input  bus64_t vs2_i,
    input  sew_t   sew_i,
    input  vxrm_t  vxrm_i,
    vmul_prod_if.mul_mp prod
);

    // full-width products for each element size
    bus128_t prod_8;
    bus128_t prod_16;
    bus128_t prod_32;
    bus128_t prod_64;
    bus128_t prod_d;

    // --------------------------------------------------
    // lane multipliers
    // --------------------------------------------------
    always_comb begin
        prod_8  = '0;
        prod_16 = '0;
        prod_32 = '0;
        for (int k = 0; k < ELEN/8; k++) begin
            prod_8[16*k +: 16] = 16'(signed'(vs1_i[8*k +: 8]) * signed'(vs2_i[8*k +: 8]));
        end
        for (int k = 0; k < ELEN/16; k++) begin
            prod_16[32*k +: 32] =
                32'(signed'(vs1_i[16*k +: 16]) * signed'(vs2_i[16*k +: 16]));
        end
        for (int k = 0; k < ELEN/32; k++) begin
            prod_32[64*k +: 64] =
                64'(signed'(vs1_i[32*k +: 32]) * signed'(vs2_i[32*k +: 32]));
        end
        prod_64 = 128'(signed'(vs1_i) * signed'(vs2_i));
    end

    // lane k lands at bit 2*SEW*k
    always_comb begin
        case (sew_i)
            SEW_8:   prod_d = prod_8;
            SEW_16:  prod_d = prod_16;
            SEW_32:  prod_d = prod_32;
            default: prod_d = prod_64;
        endcase
    end

    // --------------------------------------------------
    // product register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= valid_i;
        end
    end

    // payload with the configuration seen at issue
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            prod.prod <= prod_d;
            prod.sew  <= sew_i;
            prod.vxrm <= vxrm_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/vsmul.sv ====
// Fractional multiply rounding stage
`timescale 1ns/1ps
`default_nettype none

module vsmul
    import vfx_types_pkg::*;
    import vcsr_pkg::*;
#(
    parameter int ELEN = ELEN_C
) (
    input  logic   clk_i,
    input  logic   rst_i,
    vmul_prod_if.rnd_mp prod,
    output logic   valid_o,
    output bus64_t data_vd_o,
    output logic   sat_ovf_o
);

    localparam int NB = ELEN / 8;

    logic [NB-1:0][7:0] shifted;
    logic [NB-1:0][7:0] sum;
    logic [NB-1:0]      to_add;
    logic [NB-1:0]      carry_in;
    logic [NB-1:0]      carry_out;
    logic [NB-1:0]      ovf;
    bus64_t             vd_d;

    // increment from guard bit, sticky bits and kept lsb
    function automatic logic round_inc(vxrm_t mode, logic guard, logic sticky, logic lsb);
        case (mode)
            RNU_V:   return guard;
            RNE_V:   return guard & (sticky | lsb);
            ROD_V:   return ~lsb & (guard | sticky);
            default: return 1'b0;
        endcase
    endfunction

    // --------------------------------------------------
    // kept bits 2*SEW-2 .. SEW-1 and rounding increment
    // --------------------------------------------------
    always_comb begin
        shifted = '0;
        to_add  = '0;
        case (prod.sew)
            SEW_8: begin
                for (int k = 0; k < NB; k++) begin
                    shifted[k] = prod.prod[16*k + 7 +: 8];
                    to_add[k]  = round_inc(prod.vxrm, prod.prod[16*k + 6],
                                           |prod.prod[16*k +: 6], prod.prod[16*k + 7]);
                end
            end
            SEW_16: begin
                for (int k = 0; k < NB/2; k++) begin
                    shifted[2*k +: 2] = prod.prod[32*k + 15 +: 16];
                    to_add[2*k] = round_inc(prod.vxrm, prod.prod[32*k + 14],
                                            |prod.prod[32*k +: 14], prod.prod[32*k + 15]);
                end
            end
            SEW_32: begin
                for (int k = 0; k < NB/4; k++) begin
                    shifted[4*k +: 4] = prod.prod[64*k + 31 +: 32];
                    to_add[4*k] = round_inc(prod.vxrm, prod.prod[64*k + 30],
                                            |prod.prod[64*k +: 30], prod.prod[64*k + 31]);
                end
            end
            SEW_64: begin
                shifted   = prod.prod[63 +: 64];
                to_add[0] = round_inc(prod.vxrm, prod.prod[62], |prod.prod[61:0], prod.prod[63]);
            end
        endcase
    end

    // --------------------------------------------------
    // byte adders, chain broken at element boundaries
    // --------------------------------------------------
    always_comb begin
        int spe;
        int sign_idx;
        spe = 1 << prod.sew;
        carry_in[0] = to_add[0];
        {carry_out[0], sum[0]} = {1'b0, shifted[0]} + 9'(carry_in[0]);
        for (int j = 1; j < NB; j++) begin
            // the first byte of an element takes the rounding increment
            carry_in[j] = ((j % spe) == 0) ? to_add[j] : carry_out[j-1];
            {carry_out[j], sum[j]} = {1'b0, shifted[j]} + 9'(carry_in[j]);
        end
        // positive product whose result reads negative has overflowed
        for (int j = 0; j < NB; j++) begin
            sign_idx = (((j >> prod.sew) + 1) << (prod.sew + 4)) - 1;
            ovf[j]   = ((j % spe) == spe - 1) && !prod.prod[sign_idx] && sum[j][7];
        end
    end

    // saturated elements become 0x7f..ff
    always_comb begin
        int top;
        for (int j = 0; j < NB; j++) begin
            top = j | ((1 << prod.sew) - 1);
            if (ovf[top]) begin
                vd_d[8*j +: 8] = (j == top) ? 8'h7f : 8'hff;
            end else begin
                vd_d[8*j +: 8] = sum[j];
            end
        end
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            data_vd_o <= '0;
            sat_ovf_o <= 1'b0;
        end else begin
            valid_o   <= prod.valid;
            // flag is a one-cycle pulse, qualified with valid
            sat_ovf_o <= prod.valid & (|ovf);
            if (prod.valid) begin
                data_vd_o <= vd_d;
            end
        end
    end

endmodule

`default_nettype wire
